// ==== src/map_macros.svh ====
// Map width macros
`ifndef MAP_MACROS_SVH
`define MAP_MACROS_SVH

// level one, indexed by the top virtual address bits.
`define MAP_L1_AW 11
`define MAP_L1_DW 5

// level two, indexed by block number and page bits.
`define MAP_L2_AW 10
`define MAP_L2_DW 24

`define VADDR_W 24
`define PPAGE_W 14

// lowest virtual address bit seen by the map.
`define MAP_PAGE_LSB 8

`endif

// ==== src/map_entry_pkg.sv ====
// Map entry types
`include "map_macros.svh"

package map_entry_pkg;

   // level-one entry, names one level-two block.
   typedef logic [`MAP_L1_DW-1:0] l2_block_t;

   typedef struct packed
   {
      logic                access;
      logic                write_ok;
      logic [1:0]          meta;
      logic [5:0]          unused;
      logic [`PPAGE_W-1:0] ppage;
   } map2_fields_t;

   // one level-two word, seen raw or by field.
   typedef union packed
   {
      logic [`MAP_L2_DW-1:0] raw;
      map2_fields_t          f;
   } map2_entry_u;

endpackage

// ==== src/console_pkg.sv ====
// Console map select type
package console_pkg;

   // which map level a command or write goes to.
   typedef enum logic
   {
      MAP_L1 = 1'b0,
      MAP_L2 = 1'b1
   } map_sel_e;

endpackage

// ==== src/map_dpram.sv ====
// Dual port map memory
`timescale 1ns/1ps

module map_dpram
#(
   parameter int ADDR_W = 11,
   parameter int DATA_W = 5
)
(
   input  logic              reset,
   input  logic              clk_a,
   input  logic [ADDR_W-1:0] address_a,
   input  logic [DATA_W-1:0] data_a,
   input  logic              wren_a,
   input  logic              rden_a,
   input  logic [ADDR_W-1:0] address_b,
   input  logic [DATA_W-1:0] data_b,
   input  logic              wren_b,
   input  logic              rden_b,
   output logic [DATA_W-1:0] q_a,
   output logic [DATA_W-1:0] q_b
);

   logic [DATA_W-1:0] ram [0:(1<<ADDR_W)-1];

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[address_a] <= data_a;
      if (wren_b)
         ram[address_b] <= data_b;
   end

   // reads see the old word when a write hits the same address.
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[address_a];
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= ram[address_b];
   end

   // the arbiter keeps port b off while the translator writes.
   a_one_writer: assert property (@(posedge clk_a) disable iff (reset)
      !(wren_a && wren_b))
      else $error("map_dpram: both ports written in one cycle");

endmodule

// ==== src/map_translator.sv ====
// Map lookup translator
`timescale 1ns/1ps
`include "map_macros.svh"

module map_translator
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  logic                     lookup_stb,
   input  logic [`VADDR_W-1:0]      vaddr,
   input  logic                     map_wr_stb,
   input  console_pkg::map_sel_e    map_wr_sel,
   input  logic [`MAP_L2_DW-1:0]    map_wr_data,
   output logic                     valid,
   output logic [`PPAGE_W-1:0]      ppage,
   output logic                     access_ok,
   output logic                     write_ok,
   output logic [1:0]               meta,
   output logic                     tr_wr_l1,
   output logic                     tr_wr_l2,
   output logic [`MAP_L1_AW-1:0]    l1_address_a,
   output logic [`MAP_L1_DW-1:0]    l1_data_a,
   output logic                     l1_wren_a,
   output logic                     l1_rden_a,
   input  logic [`MAP_L1_DW-1:0]    l1_q_a,
   output logic [`MAP_L2_AW-1:0]    l2_address_a,
   output logic [`MAP_L2_DW-1:0]    l2_data_a,
   output logic                     l2_wren_a,
   output logic                     l2_rden_a,
   input  logic [`MAP_L2_DW-1:0]    l2_q_a
);

   import console_pkg::*;
   import map_entry_pkg::*;

   localparam int OFF_W = `MAP_L2_AW - `MAP_L1_DW;

   logic             s1_valid;
   logic [OFF_W-1:0] s1_off;
   l2_block_t        s2_block;
   map2_entry_u      entry;

   assign tr_wr_l1 = map_wr_stb && (map_wr_sel == MAP_L1);
   assign tr_wr_l2 = map_wr_stb && (map_wr_sel == MAP_L2);

   // lookups and writes share the level-one index bits.
   assign l1_address_a = vaddr[`VADDR_W-1 -: `MAP_L1_AW];
   assign l1_data_a    = map_wr_data[`MAP_L1_DW-1:0];
   assign l1_wren_a    = tr_wr_l1;
   assign l1_rden_a    = lookup_stb;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         valid    <= 1'b0;
      end
      else
      begin
         s1_valid <= lookup_stb;
         valid    <= s1_valid;         // level-two word is out next cycle.
      end
      s1_off <= vaddr[`MAP_PAGE_LSB +: OFF_W];
   end

   // level-two index is the block from level one plus the page bits.
   assign s2_block     = l1_q_a;
   assign l2_address_a = tr_wr_l2 ? vaddr[`MAP_PAGE_LSB +: `MAP_L2_AW] : {s2_block, s1_off};
   assign l2_data_a    = map_wr_data;
   assign l2_wren_a    = tr_wr_l2;
   assign l2_rden_a    = s1_valid;

   assign entry.raw = l2_q_a;
   assign ppage     = entry.f.ppage;
   assign access_ok = entry.f.access;
   assign write_ok  = entry.f.write_ok;
   assign meta      = entry.f.meta;

   a_stb_excl: assert property (@(posedge clk_a) disable iff (reset)
      !(lookup_stb && map_wr_stb))
      else $error("map_translator: lookup and map write strobed together");

   // a level-two write would take port a from the stage-two read.
   a_l2_free: assert property (@(posedge clk_a) disable iff (reset)
      lookup_stb |=> !tr_wr_l2)
      else $error("map_translator: level-two write right after a lookup");

endmodule

// ==== src/console_map_access.sv ====
// Console map access sequencer
`timescale 1ns/1ps
`include "map_macros.svh"

module console_map_access
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  logic                     cmd_stb,
   input  console_pkg::map_sel_e    cmd_sel,
   input  logic [`MAP_L1_AW-1:0]    cmd_addr,
   input  logic [`MAP_L2_DW-1:0]    cmd_wdata,
   input  logic                     cmd_wr,
   input  logic                     con_gnt,
   input  logic [`MAP_L2_DW-1:0]    con_rdata,
   output logic                     busy,
   output logic                     done,
   output logic [`MAP_L2_DW-1:0]    rdata,
   output logic                     con_req,
   output console_pkg::map_sel_e    con_sel,
   output logic [`MAP_L1_AW-1:0]    con_addr,
   output logic [`MAP_L2_DW-1:0]    con_wdata,
   output logic                     con_wr
);

   import console_pkg::*;
   import map_entry_pkg::*;

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_REQ,
      ST_RD_WAIT
   } state_e;

   state_e                state;
   map_sel_e              sel_q;
   logic [`MAP_L1_AW-1:0] addr_q;
   logic                  wr_q;
   map2_entry_u           wdata_q;
   map2_entry_u           rdata_q;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         done  <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            ST_IDLE:
               if (cmd_stb)
                  state <= ST_REQ;
            ST_REQ:
               if (con_gnt)
               begin
                  state <= wr_q ? ST_IDLE : ST_RD_WAIT;
                  done  <= wr_q;       // write landed at this edge.
               end
            default:
            begin
               state <= ST_IDLE;
               done  <= 1'b1;
            end
         endcase
      end

      if (state == ST_IDLE && cmd_stb)
      begin
         sel_q       <= cmd_sel;
         addr_q      <= cmd_addr;
         wr_q        <= cmd_wr;
         wdata_q.raw <= cmd_wdata;
      end
      if (state == ST_RD_WAIT)
         rdata_q.raw <= con_rdata;     // q_b came out on the grant edge.
   end

   assign busy      = (state != ST_IDLE);
   assign con_req   = (state == ST_REQ);
   assign con_sel   = sel_q;
   assign con_addr  = addr_q;
   assign con_wr    = wr_q;
   assign con_wdata = wdata_q.raw;
   assign rdata     = rdata_q.raw;

   a_no_stb_busy: assert property (@(posedge clk_a) disable iff (reset)
      busy |-> !cmd_stb)
      else $error("console_map_access: command strobed while busy");

endmodule

// ==== src/map_arbiter.sv ====
// Port b arbiter
`timescale 1ns/1ps
`include "map_macros.svh"

module map_arbiter
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  logic                     con_req,
   input  console_pkg::map_sel_e    con_sel,
   input  logic [`MAP_L1_AW-1:0]    con_addr,
   input  logic [`MAP_L2_DW-1:0]    con_wdata,
   input  logic                     con_wr,
   input  logic                     tr_wr_l1,
   input  logic                     tr_wr_l2,
   input  logic [`MAP_L1_DW-1:0]    l1_q_b,
   input  logic [`MAP_L2_DW-1:0]    l2_q_b,
   output logic                     con_gnt,
   output logic [`MAP_L2_DW-1:0]    con_rdata,
   output logic [`MAP_L1_AW-1:0]    l1_address_b,
   output logic [`MAP_L1_DW-1:0]    l1_data_b,
   output logic                     l1_wren_b,
   output logic                     l1_rden_b,
   output logic [`MAP_L2_AW-1:0]    l2_address_b,
   output logic [`MAP_L2_DW-1:0]    l2_data_b,
   output logic                     l2_wren_b,
   output logic                     l2_rden_b
);

   import console_pkg::*;

   map_sel_e rd_sel;
   logic     sel_l1;
   logic     sel_l2;

   assign sel_l1 = (con_sel == MAP_L1);
   assign sel_l2 = (con_sel == MAP_L2);

   // the translator always wins its own memory.
   assign con_gnt = con_req && !(sel_l1 ? tr_wr_l1 : tr_wr_l2);

   assign l1_address_b = con_addr;
   assign l1_data_b    = con_wdata[`MAP_L1_DW-1:0];
   assign l1_wren_b    = con_gnt && sel_l1 && con_wr;
   assign l1_rden_b    = con_gnt && sel_l1 && !con_wr;

   assign l2_address_b = con_addr[`MAP_L2_AW-1:0];
   assign l2_data_b    = con_wdata;
   assign l2_wren_b    = con_gnt && sel_l2 && con_wr;
   assign l2_rden_b    = con_gnt && sel_l2 && !con_wr;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         rd_sel <= MAP_L1;
      else if (con_gnt)
         rd_sel <= con_sel;             // picks the q_b of the next cycle.
   end

   assign con_rdata = (rd_sel == MAP_L2) ? l2_q_b :
                      {{(`MAP_L2_DW-`MAP_L1_DW){1'b0}}, l1_q_b};

   // a waiting console keeps its request and target until granted.
   a_req_held: assert property (@(posedge clk_a) disable iff (reset)
      con_req && !con_gnt |=> con_req && $stable(con_sel) && $stable(con_addr))
      else $error("map_arbiter: console request changed before its grant");

endmodule

// ==== src/cadr_map.sv ====
// Two-level map top
`timescale 1ns/1ps
`include "map_macros.svh"

module cadr_map
(
   input  logic                     clk_a,
   input  logic                     reset,
   input  logic                     lookup_stb,
   input  logic [`VADDR_W-1:0]      vaddr,
   input  logic                     map_wr_stb,
   input  console_pkg::map_sel_e    map_wr_sel,
   input  logic [`MAP_L2_DW-1:0]    map_wr_data,
   output logic                     valid,
   output logic [`PPAGE_W-1:0]      ppage,
   output logic                     access_ok,
   output logic                     write_ok,
   output logic [1:0]               meta,
   input  logic                     cmd_stb,
   input  console_pkg::map_sel_e    cmd_sel,
   input  logic [`MAP_L1_AW-1:0]    cmd_addr,
   input  logic [`MAP_L2_DW-1:0]    cmd_wdata,
   input  logic                     cmd_wr,
   output logic                     busy,
   output logic                     done,
   output logic [`MAP_L2_DW-1:0]    rdata
);

   import console_pkg::*;

   logic [`MAP_L1_AW-1:0] l1_address_a, l1_address_b, con_addr;
   logic [`MAP_L1_DW-1:0] l1_data_a, l1_data_b, l1_q_a, l1_q_b;
   logic [`MAP_L2_AW-1:0] l2_address_a, l2_address_b;
   logic [`MAP_L2_DW-1:0] l2_data_a, l2_data_b, l2_q_a, l2_q_b;
   logic [`MAP_L2_DW-1:0] con_wdata, con_rdata;
   logic                  l1_wren_a, l1_rden_a, l1_wren_b, l1_rden_b;
   logic                  l2_wren_a, l2_rden_a, l2_wren_b, l2_rden_b;
   logic                  tr_wr_l1, tr_wr_l2;
   logic                  con_req, con_gnt, con_wr;
   map_sel_e              con_sel;

   map_translator i_translator (.*);

   console_map_access i_console (.*);

   map_arbiter i_arbiter (.*);

   map_dpram #(.ADDR_W(`MAP_L1_AW), .DATA_W(`MAP_L1_DW)) i_l1_map
   (
      .reset(reset), .clk_a(clk_a),
      .address_a(l1_address_a), .data_a(l1_data_a),
      .wren_a(l1_wren_a), .rden_a(l1_rden_a),
      .address_b(l1_address_b), .data_b(l1_data_b),
      .wren_b(l1_wren_b), .rden_b(l1_rden_b),
      .q_a(l1_q_a), .q_b(l1_q_b)
   );

   // level two is 1024 words, 32 per block.
   map_dpram #(.ADDR_W(`MAP_L2_AW), .DATA_W(`MAP_L2_DW)) i_l2_map
   (
      .reset(reset), .clk_a(clk_a),
      .address_a(l2_address_a), .data_a(l2_data_a),
      .wren_a(l2_wren_a), .rden_a(l2_rden_a),
      .address_b(l2_address_b), .data_b(l2_data_b),
      .wren_b(l2_wren_b), .rden_b(l2_rden_b),
      .q_a(l2_q_a), .q_b(l2_q_b)
   );

endmodule

// ==== test/tb_map_model.svh ====
// Map reference model
`ifndef TB_MAP_MODEL_SVH
`define TB_MAP_MODEL_SVH

// model copies of both map levels.
logic [`MAP_L1_DW-1:0] model_l1 [0:(1<<`MAP_L1_AW)-1];
logic [`MAP_L2_DW-1:0] model_l2 [0:(1<<`MAP_L2_AW)-1];
logic [15:0]           lfsr_state = 16'd52;

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit.
function automatic logic [31:0] lfsr_bits(input int n);
   logic [31:0] bits;
   logic        fb;
   bits = '0;
   for (int i = 0; i < n; i++)
   begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      bits       = {bits[30:0], fb};
   end
   return bits;
endfunction

// level one names the block, the page bits pick the word in it.
function automatic logic [`MAP_L2_DW-1:0] ref_lookup(input logic [`VADDR_W-1:0] va);
   logic [`MAP_L1_DW-1:0] block;
   block = model_l1[va[23:13]];
   return model_l2[{block, va[12:8]}];
endfunction

function automatic void model_write(input map_sel_e sel, input logic [`VADDR_W-1:0] va,
                                    input logic [`MAP_L2_DW-1:0] data);
   if (sel == MAP_L2)
      model_l2[va[17:8]] = data;
   else
      model_l1[va[23:13]] = data[4:0];     // level one keeps 5 bits.
endfunction

`endif

// ==== test/tb_cadr_map.sv ====
// Two-level map testbench
`timescale 1ns/1ps
`include "map_macros.svh"

module tb_cadr_map;

   import console_pkg::*;

   localparam int N_READS   = 24;
   localparam int N_LOOKUPS = 64;
   localparam int N_WR_LOOK = 8;
   localparam int N_ROUNDS  = 4;
   localparam int STRETCH   = 20;
   localparam int FILL      = (1 << `MAP_L1_AW) + (1 << `MAP_L2_AW);
   // each phase at its slowest, doubled.
   localparam int MAX_CYCLES = 2 * (40 + FILL + 4 * N_READS * 8 + 2 * N_LOOKUPS
                                    + N_WR_LOOK * 4 + N_ROUNDS * (STRETCH + 24));

   logic                  clk_a, reset, lookup_stb, map_wr_stb, cmd_stb, cmd_wr;
   logic [`VADDR_W-1:0]   vaddr;
   map_sel_e              map_wr_sel, cmd_sel;
   logic [`MAP_L2_DW-1:0] map_wr_data, cmd_wdata, rdata;
   logic [`MAP_L1_AW-1:0] cmd_addr;
   logic                  valid, access_ok, write_ok, busy, done;
   logic [`PPAGE_W-1:0]   ppage;
   logic [1:0]            meta;
   int                    errors, checks, tests_run, tests_failed, errors_at_start;
   int                    cycle_count;
   logic [`MAP_L2_DW-1:0] exp_q [$];
   logic [`VADDR_W-1:0]   va_q [$];
   int                    cyc_q [$];

   `include "tb_map_model.svh"

   cadr_map i_dut (.*);

   initial
   begin
      clk_a = 1'b0;
      forever #2 clk_a = ~clk_a;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES)
      begin
         @(posedge clk_a);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // access 23, write_ok 22, meta 21:20, ppage 13:0.
   function automatic logic [17:0] lookup_view(input logic [23:0] e);
      return {e[23], e[22], e[21:20], e[13:0]};
   endfunction

   // sampled mid-cycle, away from the driving edge.
   initial
   begin
      forever
      begin
         @(negedge clk_a);
         if (!reset && valid)
         begin
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("valid pulse at %0t ns with no lookup outstanding", $time);
            end
            else
            begin
               check_equal(32'({access_ok, write_ok, meta, ppage}),
                           32'(lookup_view(exp_q.pop_front())),
                           $sformatf("lookup of %h", va_q.pop_front()));
               check_equal(32'(cycle_count - cyc_q.pop_front()), 32'd2, "lookup latency");
            end
         end
         if (!reset && lookup_stb)
         begin
            exp_q.push_back(ref_lookup(vaddr));
            va_q.push_back(vaddr);
            cyc_q.push_back(cycle_count);
         end
      end
   end

   task automatic drive_write(input map_sel_e sel, input logic [`VADDR_W-1:0] va,
                              input logic [`MAP_L2_DW-1:0] data);
      @(posedge clk_a);
      map_wr_stb  <= 1'b1;
      map_wr_sel  <= sel;
      vaddr       <= va;
      map_wr_data <= data;
      lookup_stb  <= 1'b0;
      cmd_stb     <= 1'b0;
      model_write(sel, va, data);
   endtask

   task automatic drive_lookup(input logic [`VADDR_W-1:0] va);
      @(posedge clk_a);
      lookup_stb <= 1'b1;
      vaddr      <= va;
      map_wr_stb <= 1'b0;
      cmd_stb    <= 1'b0;
   endtask

   task automatic drive_idle();
      @(posedge clk_a);
      lookup_stb <= 1'b0;
      map_wr_stb <= 1'b0;
      cmd_stb    <= 1'b0;
   endtask

   task automatic start_cmd(input map_sel_e sel, input logic [`MAP_L1_AW-1:0] addr,
                            input logic wr, input logic [`MAP_L2_DW-1:0] data);
      @(posedge clk_a);
      cmd_stb   <= 1'b1;
      cmd_sel   <= sel;
      cmd_addr  <= addr;
      cmd_wr    <= wr;
      cmd_wdata <= data;
   endtask

   // busy stays up until the command ends with done.
   task automatic wait_done();
      do
      begin
         @(negedge clk_a);
         check_equal(32'(busy), 32'(!done), "console busy");
      end
      while (!done);
   endtask

   task automatic drain_lookups();
      while (exp_q.size() != 0)
         @(negedge clk_a);
   endtask

   task automatic console_check(input map_sel_e sel, input logic [`MAP_L1_AW-1:0] addr);
      logic [31:0] exp;
      exp = (sel == MAP_L2) ? 32'(model_l2[addr[9:0]]) : 32'(model_l1[addr]);
      start_cmd(sel, addr, 1'b0, '0);
      drive_idle();
      wait_done();
      check_equal(32'(rdata), exp, $sformatf("console read %s %h", sel.name(), addr));
   endtask

   task automatic random_reads();
      for (int i = 0; i < N_READS; i++)
      begin
         console_check(MAP_L1, 11'(lfsr_bits(11)));
         console_check(MAP_L2, 11'(lfsr_bits(10)));
      end
   endtask

   task automatic random_lookups();
      for (int i = 0; i < N_LOOKUPS; i++)
         drive_lookup(24'(lfsr_bits(24)));
      drive_idle();
      drain_lookups();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != errors_at_start)
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
      end
      else
         $display("test %0d %s: ok", tests_run, name);
      errors_at_start = errors;
   endtask

   initial
   begin
      logic [`VADDR_W-1:0]   va;
      logic [`MAP_L1_AW-1:0] caddr;
      logic [`MAP_L2_DW-1:0] cdata;
      map_sel_e              sel;
      reset       = 1'b1;
      lookup_stb  = 1'b0;
      map_wr_stb  = 1'b0;
      map_wr_sel  = MAP_L1;
      vaddr       = '0;
      map_wr_data = '0;
      cmd_stb     = 1'b0;
      cmd_sel     = MAP_L1;
      cmd_addr    = '0;
      cmd_wdata   = '0;
      cmd_wr      = 1'b0;
      repeat (4) @(posedge clk_a);
      reset <= 1'b0;

      repeat (8)
      begin
         @(negedge clk_a);
         check_equal(32'({valid, done, busy}), 32'd0, "valid, done, busy after reset");
         check_equal(32'({access_ok, write_ok, meta, ppage}), 32'd0, "lookup outputs after reset");
      end
      end_test("reset");

      for (int a = 0; a < (1 << `MAP_L1_AW); a++)
         drive_write(MAP_L1, {11'(a), 13'd0}, 24'(lfsr_bits(5)));
      for (int a = 0; a < (1 << `MAP_L2_AW); a++)
         drive_write(MAP_L2, {6'd0, 10'(a), 8'd0}, 24'(lfsr_bits(24)));
      drive_idle();
      random_reads();
      end_test("fill and readback");

      random_lookups();
      end_test("lookups");

      for (int i = 0; i < N_WR_LOOK; i++)
      begin
         va = 24'(lfsr_bits(24));
         drive_write(MAP_L2, {6'd0, model_l1[va[23:13]], va[12:8], 8'd0}, 24'(lfsr_bits(24)));
         drive_lookup(va);
         drive_idle();                  // gap before the next level-two write.
      end
      drain_lookups();
      end_test("write then lookup");

      for (int r = 0; r < N_ROUNDS; r++)
      begin
         sel   = (r % 2 == 0) ? MAP_L2 : MAP_L1;
         caddr = 11'(lfsr_bits(11));
         cdata = 24'(lfsr_bits(24));
         start_cmd(sel, caddr, 1'b1, cdata);
         for (int i = 0; i < STRETCH; i++)
         begin
            va = 24'(lfsr_bits(24));
            if (i == STRETCH / 2)
               va = (sel == MAP_L2) ? {6'd0, caddr[9:0], 8'd0} : {caddr, 13'd0};
            drive_write(sel, va, 24'(lfsr_bits(24)));
         end
         drive_idle();
         wait_done();
         // console write lands after the last processor write.
         if (sel == MAP_L2)
            model_l2[caddr[9:0]] = cdata;
         else
            model_l1[caddr] = cdata[4:0];
         console_check(sel, caddr);
      end
      random_lookups();
      random_reads();
      end_test("contention");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== cadr_map.f ====
+incdir+src
+incdir+test
src/map_entry_pkg.sv
src/console_pkg.sv
src/map_dpram.sv
src/map_translator.sv
src/console_map_access.sv
src/map_arbiter.sv
src/cadr_map.sv
test/tb_cadr_map.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_cadr_map

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

$(SIM): cadr_map.f $(wildcard src/*.sv src/*.svh test/*.sv test/*.svh)
	verilator --binary --timing --assert --top-module tb_cadr_map -f cadr_map.f

clean:
	rm -rf obj_dir sim.log
